// File: build.f
+incdir+src
src/common_pkg.sv
src/route_pkg.sv
src/tile_router.sv
src/tile_mem.sv
src/mini_core_tile.sv
src/fabric.sv
testbench/fabric_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = fabric_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/fabric_tb.sv
// host-side testbench for the 3x3 mesh; scratchpads are not reset, so only written words are read
`timescale 1ns/1ns
`include "fabric_config.svh"

module fabric_tb;
    import common_pkg::*;

    localparam int NUM_TILES = `FAB_COLS * `FAB_ROWS;
    localparam int TIMEOUT   = 400;

    logic        clk;
    logic        reset;
    logic        host_req_valid;
    t_tile_trans host_req;
    t_fab_ready  host_req_ready;
    logic        host_rsp_valid;
    t_tile_trans host_rsp;
    t_fab_ready  host_rsp_ready;

    // reference memory and outstanding requests, per tile and address
    logic [`DATA_W-1:0] model    [NUM_TILES][`MEM_DEPTH];
    logic               pending  [NUM_TILES][`MEM_DEPTH];
    t_opcode            exp_op   [NUM_TILES][`MEM_DEPTH];
    logic [`DATA_W-1:0] exp_data [NUM_TILES][`MEM_DEPTH];

    integer      seed;
    int          errors;
    int          sent;
    int          received;
    int          tests_run;
    logic        aborted;
    logic        sent_any;
    logic        random_ready;
    logic [31:0] ready_bits;
    logic        held;
    t_tile_trans held_rsp;

    fabric i_fabric (.*);

    always #20 clk = ~clk;

    function automatic int tile_index(int col, int row);
        return (row - 1) * `FAB_COLS + (col - 1);
    endfunction

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    //============================================================
    // host request side
    //============================================================
    task automatic send(t_opcode op, int col, int row, logic [ADDR_W-1:0] addr,
                        logic [`DATA_W-1:0] data);
        int idx;
        int waited;
        if (aborted) return;
        idx = tile_index(col, row);
        host_req_valid             = 1'b1;
        host_req.opcode            = op;
        host_req.dst               = '{col: 4'(col), row: 4'(row)};
        host_req.src               = HOST_ID;
        host_req.payload.req.addr  = addr;
        host_req.payload.req.wr_data = data;
        waited = 0;
        #1;
        while (!host_req_ready) begin
            if (waited == TIMEOUT) begin
                $display("timeout: request to tile [%0d,%0d] never accepted", col, row);
                aborted = 1'b1;
                host_req_valid = 1'b0;
                return;
            end
            @(posedge clk);
            #3;
            waited++;
        end
        // ready is state only, so the transfer happens on the coming edge
        if (op == OP_WR_REQ)
            model[idx][addr] = data;
        pending[idx][addr]  = 1'b1;
        exp_op[idx][addr]   = (op == OP_WR_REQ) ? OP_WR_ACK : OP_RD_RSP;
        exp_data[idx][addr] = model[idx][addr];
        sent++;
        sent_any = 1'b1;
        next_cycle();
        host_req_valid = 1'b0;
    endtask

    task automatic wait_all();
        int waited;
        waited = 0;
        while (!aborted && received != sent) begin
            if (waited == TIMEOUT) begin
                $display("timeout: %0d responses still missing", sent - received);
                aborted = 1'b1;
                return;
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        $display("test %0d %s: %s, errors so far %0d", tests_run, name,
                 aborted ? "aborted" : "done", errors);
    endtask

    //============================================================
    // response checks
    //============================================================
    a_quiet: assert property (@(posedge clk) disable iff (reset) !sent_any |-> !host_rsp_valid)
        else begin
            $display("host_rsp_valid went high before any request was sent");
            errors++;
        end

    always @(posedge clk) begin
        int                idx;
        logic [ADDR_W-1:0] addr;
        if (!reset) begin
            if (held) begin
                a_valid_held: assert (host_rsp_valid) else begin
                    $display("host_rsp_valid dropped while host_rsp_ready was low");
                    errors++;
                end
                a_rsp_held: assert (host_rsp == held_rsp) else begin
                    $display("** Error: host_rsp expected %h actual %h", held_rsp, host_rsp);
                    errors++;
                end
            end
            held     = host_rsp_valid && !host_rsp_ready;
            held_rsp = host_rsp;
            if (host_rsp_valid && host_rsp_ready) begin
                idx  = tile_index(int'(host_rsp.src.col), int'(host_rsp.src.row));
                addr = host_rsp.payload.rsp.addr;
                a_src: assert (host_rsp.src.col inside {[1:`FAB_COLS]} &&
                               host_rsp.src.row inside {[1:`FAB_ROWS]}) else begin
                    $display("response source %h is not a tile of the mesh", host_rsp.src);
                    errors++;
                    idx = 0;
                end
                a_known: assert (pending[idx][addr]) else begin
                    $display("response from %h address %h had no request outstanding",
                             host_rsp.src, addr);
                    errors++;
                end
                a_dst: assert (host_rsp.dst == HOST_ID) else begin
                    $display("** Error: host_rsp.dst expected %h actual %h",
                             HOST_ID, host_rsp.dst);
                    errors++;
                end
                a_op: assert (host_rsp.opcode == exp_op[idx][addr]) else begin
                    $display("** Error: host_rsp.opcode expected %h actual %h",
                             exp_op[idx][addr], host_rsp.opcode);
                    errors++;
                end
                a_data: assert (host_rsp.payload.rsp.rd_data == exp_data[idx][addr]) else begin
                    $display("** Error: host_rsp.payload.rsp.rd_data expected %h actual %h",
                             exp_data[idx][addr], host_rsp.payload.rsp.rd_data);
                    errors++;
                end
                pending[idx][addr] = 1'b0;
                received++;
            end
        end
    end

    // host takes responses at random when enabled
    always @(posedge clk) begin
        #2;
        if (random_ready) begin
            ready_bits     = next_random();
            host_rsp_ready = ready_bits[1];
        end else begin
            host_rsp_ready = 1'b1;
        end
    end

    //============================================================
    // test sequence
    //============================================================
    initial begin
        logic [31:0] rnd;
        int          col;
        int          row;
        clk = 1'b0;
        reset = 1'b1;
        host_req_valid = 1'b0;
        host_req = '0;
        host_rsp_ready = 1'b1;
        seed = 95;
        errors = 0;
        sent = 0;
        received = 0;
        tests_run = 0;
        aborted = 1'b0;
        sent_any = 1'b0;
        random_ready = 1'b0;
        held = 1'b0;
        held_rsp = '0;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int a = 0; a < `MEM_DEPTH; a++) begin
                pending[t][a] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (8) next_cycle();
        end_test("quiet after reset");

        for (int r = 1; r <= `FAB_ROWS; r++) begin
            for (int c = 1; c <= `FAB_COLS; c++) begin
                rnd = next_random();
                send(OP_WR_REQ, c, r, ADDR_W'(tile_index(c, r)), rnd[`DATA_W-1:0]);
                wait_all();
            end
        end
        end_test("write each tile");

        for (int r = 1; r <= `FAB_ROWS; r++) begin
            for (int c = 1; c <= `FAB_COLS; c++) begin
                send(OP_RD_REQ, c, r, ADDR_W'(tile_index(c, r)), '0);
                wait_all();
            end
        end
        end_test("read each tile");

        // same address everywhere, each tile keeps its own word
        for (int t = 0; t < NUM_TILES; t++) begin
            rnd = next_random();
            send(OP_WR_REQ, t % `FAB_COLS + 1, t / `FAB_COLS + 1, 4'hA, rnd[`DATA_W-1:0]);
            wait_all();
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            send(OP_RD_REQ, t % `FAB_COLS + 1, t / `FAB_COLS + 1, 4'hA, '0);
            wait_all();
        end
        end_test("same address on all tiles");

        random_ready = 1'b1;
        for (int n = 0; n < 12; n++) begin
            rnd = next_random();
            col = 1 + int'(rnd[7:0]) % `FAB_COLS;
            row = 1 + int'(rnd[15:8]) % `FAB_ROWS;
            send(OP_WR_REQ, col, row, rnd[16+ADDR_W-1:16], `DATA_W'(next_random() >> 8));
            wait_all();
            send(OP_RD_REQ, col, row, rnd[16+ADDR_W-1:16], '0);
            wait_all();
        end
        end_test("random response stalls");

        // far corner first, nothing waits between requests
        for (int t = NUM_TILES - 1; t >= 0; t--) begin
            rnd = next_random();
            send(OP_WR_REQ, t % `FAB_COLS + 1, t / `FAB_COLS + 1, 4'h5, rnd[`DATA_W-1:0]);
        end
        wait_all();
        for (int t = NUM_TILES - 1; t >= 0; t--) begin
            send(OP_RD_REQ, t % `FAB_COLS + 1, t / `FAB_COLS + 1, 4'h5, '0);
        end
        wait_all();
        random_ready = 1'b0;
        repeat (10) next_cycle();
        end_test("back-to-back distant requests");

        $display("tests %0d, requests %0d, responses %0d, errors %0d",
                 tests_run, sent, received, errors);
        if (errors == 0 && !aborted && received == sent) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src/fabric.sv
// mesh top; only the west side of tile [1,1] is open for the host, every other edge is tied off
`timescale 1ns/1ns
`include "fabric_config.svh"

module fabric (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    host_req_valid,
    input  common_pkg::t_tile_trans host_req,
    output common_pkg::t_fab_ready  host_req_ready,
    output logic                    host_rsp_valid,
    output common_pkg::t_tile_trans host_rsp,
    input  common_pkg::t_fab_ready  host_rsp_ready
);
    import common_pkg::*;

    localparam int LAST_C = `FAB_COLS + 1;
    localparam int LAST_R = `FAB_ROWS + 1;

    // tile outputs over the whole frame, border cells are tie-offs
    logic        [LAST_C:0][LAST_R:0] out_north_req_valid, out_east_req_valid;
    logic        [LAST_C:0][LAST_R:0] out_south_req_valid, out_west_req_valid;
    t_tile_trans [LAST_C:0][LAST_R:0] out_north_req, out_east_req, out_south_req, out_west_req;
    t_fab_ready  [LAST_C:0][LAST_R:0] out_north_ready, out_east_ready;
    t_fab_ready  [LAST_C:0][LAST_R:0] out_south_ready, out_west_ready;
    // tile inputs, interior cells only
    logic        [`FAB_COLS:1][`FAB_ROWS:1] in_north_req_valid, in_east_req_valid;
    logic        [`FAB_COLS:1][`FAB_ROWS:1] in_south_req_valid, in_west_req_valid;
    t_tile_trans [`FAB_COLS:1][`FAB_ROWS:1] in_north_req, in_east_req, in_south_req, in_west_req;
    t_fab_ready  [`FAB_COLS:1][`FAB_ROWS:1] in_north_ready, in_east_ready;
    t_fab_ready  [`FAB_COLS:1][`FAB_ROWS:1] in_south_ready, in_west_ready;
    logic                                   edge_leak;

    //============================================================
    // frame border, everything tied to zero
    //============================================================
    for (genvar c = 0; c <= LAST_C; c++) begin : g_edge_col
        for (genvar r = 0; r <= LAST_R; r++) begin : g_edge_row
            if (c == 0 || c == LAST_C || r == 0 || r == LAST_R) begin : g_strap
                assign out_north_req_valid[c][r] = 1'b0;
                assign out_east_req_valid[c][r]  = 1'b0;
                assign out_south_req_valid[c][r] = 1'b0;
                assign out_west_req_valid[c][r]  = 1'b0;
                assign out_north_req[c][r]       = '0;
                assign out_east_req[c][r]        = '0;
                assign out_south_req[c][r]       = '0;
                assign out_west_req[c][r]        = '0;
                assign out_north_ready[c][r]     = 1'b0;
                assign out_east_ready[c][r]      = 1'b0;
                assign out_south_ready[c][r]     = 1'b0;
                assign out_west_ready[c][r]      = 1'b0;
            end
        end
    end

    //============================================================
    // neighbour links, border tiles see the tie-offs
    //============================================================
    always_comb begin
        for (int c = 1; c <= `FAB_COLS; c++) begin
            for (int r = 1; r <= `FAB_ROWS; r++) begin
                in_north_req_valid[c][r] = out_south_req_valid[c][r-1];
                in_north_req[c][r]       = out_south_req[c][r-1];
                in_north_ready[c][r]     = out_south_ready[c][r-1];
                in_south_req_valid[c][r] = out_north_req_valid[c][r+1];
                in_south_req[c][r]       = out_north_req[c][r+1];
                in_south_ready[c][r]     = out_north_ready[c][r+1];
                in_east_req_valid[c][r]  = out_west_req_valid[c+1][r];
                in_east_req[c][r]        = out_west_req[c+1][r];
                in_east_ready[c][r]      = out_west_ready[c+1][r];
                in_west_req_valid[c][r]  = out_east_req_valid[c-1][r];
                in_west_req[c][r]        = out_east_req[c-1][r];
                in_west_ready[c][r]      = out_east_ready[c-1][r];
            end
        end
        // host link replaces the west tie-off of tile [1,1]
        in_west_req_valid[1][1] = host_req_valid;
        in_west_req[1][1]       = host_req;
        in_west_ready[1][1]     = host_rsp_ready;
    end

    assign host_req_ready = out_west_ready[1][1];
    assign host_rsp_valid = out_west_req_valid[1][1];
    assign host_rsp       = out_west_req[1][1];

    //============================================================
    // tile grid
    //============================================================
    for (genvar c = 1; c <= `FAB_COLS; c++) begin : g_col
        for (genvar r = 1; r <= `FAB_ROWS; r++) begin : g_row
            mini_core_tile i_tile (
                .clk                 (clk),
                .reset               (reset),
                // {col, row}
                .local_tile_id       ({4'(c), 4'(r)}),
                .in_north_req_valid  (in_north_req_valid[c][r]),
                .in_north_req        (in_north_req[c][r]),
                .out_north_ready     (out_north_ready[c][r]),
                .out_north_req_valid (out_north_req_valid[c][r]),
                .out_north_req       (out_north_req[c][r]),
                .in_north_ready      (in_north_ready[c][r]),
                .in_east_req_valid   (in_east_req_valid[c][r]),
                .in_east_req         (in_east_req[c][r]),
                .out_east_ready      (out_east_ready[c][r]),
                .out_east_req_valid  (out_east_req_valid[c][r]),
                .out_east_req        (out_east_req[c][r]),
                .in_east_ready       (in_east_ready[c][r]),
                .in_west_req_valid   (in_west_req_valid[c][r]),
                .in_west_req         (in_west_req[c][r]),
                .out_west_ready      (out_west_ready[c][r]),
                .out_west_req_valid  (out_west_req_valid[c][r]),
                .out_west_req        (out_west_req[c][r]),
                .in_west_ready       (in_west_ready[c][r]),
                .in_south_req_valid  (in_south_req_valid[c][r]),
                .in_south_req        (in_south_req[c][r]),
                .out_south_ready     (out_south_ready[c][r]),
                .out_south_req_valid (out_south_req_valid[c][r]),
                .out_south_req       (out_south_req[c][r]),
                .in_south_ready      (in_south_ready[c][r])
            );
        end
    end

    // routing must never push a transaction off the mesh, the host side excepted
    always_comb begin
        edge_leak = 1'b0;
        for (int c = 1; c <= `FAB_COLS; c++) begin
            edge_leak |= out_north_req_valid[c][1] | out_south_req_valid[c][`FAB_ROWS];
        end
        for (int r = 1; r <= `FAB_ROWS; r++) begin
            edge_leak |= out_east_req_valid[`FAB_COLS][r];
            if (r != 1)
                edge_leak |= out_west_req_valid[1][r];
        end
    end

    a_no_edge_leak: assert property (@(posedge clk) disable iff (reset) !edge_leak);

endmodule

// File: src/mini_core_tile.sv
// one mesh tile; the scratchpad sits on the router local port, so a tile never addresses itself
`timescale 1ns/1ns

module mini_core_tile (
    input  logic                    clk,
    input  logic                    reset,
    input  common_pkg::t_tile_id    local_tile_id,
    // north
    input  logic                    in_north_req_valid,
    input  common_pkg::t_tile_trans in_north_req,
    output common_pkg::t_fab_ready  out_north_ready,
    output logic                    out_north_req_valid,
    output common_pkg::t_tile_trans out_north_req,
    input  common_pkg::t_fab_ready  in_north_ready,
    // east
    input  logic                    in_east_req_valid,
    input  common_pkg::t_tile_trans in_east_req,
    output common_pkg::t_fab_ready  out_east_ready,
    output logic                    out_east_req_valid,
    output common_pkg::t_tile_trans out_east_req,
    input  common_pkg::t_fab_ready  in_east_ready,
    // west
    input  logic                    in_west_req_valid,
    input  common_pkg::t_tile_trans in_west_req,
    output common_pkg::t_fab_ready  out_west_ready,
    output logic                    out_west_req_valid,
    output common_pkg::t_tile_trans out_west_req,
    input  common_pkg::t_fab_ready  in_west_ready,
    // south
    input  logic                    in_south_req_valid,
    input  common_pkg::t_tile_trans in_south_req,
    output common_pkg::t_fab_ready  out_south_ready,
    output logic                    out_south_req_valid,
    output common_pkg::t_tile_trans out_south_req,
    input  common_pkg::t_fab_ready  in_south_ready
);
    import common_pkg::*;

    // local link, router side to scratchpad side
    logic        mem_req_valid;
    t_tile_trans mem_req;
    t_fab_ready  mem_req_ready;
    logic        mem_rsp_valid;
    t_tile_trans mem_rsp;
    t_fab_ready  mem_rsp_ready;

    // mesh ports share their names with the tile ports
    tile_router i_router (
        .*,
        .in_local_req_valid  (mem_rsp_valid),
        .in_local_req        (mem_rsp),
        .out_local_ready     (mem_rsp_ready),
        .out_local_req_valid (mem_req_valid),
        .out_local_req       (mem_req),
        .in_local_ready      (mem_req_ready)
    );

    tile_mem i_mem (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (mem_req_valid),
        .req           (mem_req),
        .req_ready     (mem_req_ready),
        .rsp_valid     (mem_rsp_valid),
        .rsp           (mem_rsp),
        .rsp_ready     (mem_rsp_ready),
        .local_tile_id (local_tile_id)
    );

endmodule

// File: src/tile_mem.sv
// scratchpad with a single response slot; a new request waits until the held response is taken
`timescale 1ns/1ns
`include "fabric_config.svh"

module tile_mem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  common_pkg::t_tile_trans req,
    output common_pkg::t_fab_ready  req_ready,
    output logic                    rsp_valid,
    output common_pkg::t_tile_trans rsp,
    input  common_pkg::t_fab_ready  rsp_ready,
    input  common_pkg::t_tile_id    local_tile_id
);
    import common_pkg::*;

    logic [`DATA_W-1:0] mem [`MEM_DEPTH];
    logic               rsp_vld_q;
    t_tile_trans        rsp_q;
    logic               accept;
    logic               is_write;

    assign req_ready = !rsp_vld_q;
    assign accept    = req_valid && req_ready;
    assign is_write  = (req.opcode == OP_WR_REQ);
    assign rsp_valid = rsp_vld_q;
    assign rsp       = rsp_q;

    // slot fills on accept, empties when the router local input takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_vld_q <= 1'b0;
        end else if (accept) begin
            rsp_vld_q <= 1'b1;
        end else if (rsp_ready) begin
            rsp_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_write) begin
            mem[req.payload.req.addr] <= req.payload.req.wr_data;
        end
    end

    // answer goes back to the sender, a write ack echoes the written word
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_q.opcode              <= is_write ? OP_WR_ACK : OP_RD_RSP;
            rsp_q.dst                 <= req.src;
            rsp_q.src                 <= local_tile_id;
            rsp_q.payload.rsp.addr    <= req.payload.req.addr;
            rsp_q.payload.rsp.rd_data <= is_write ? req.payload.req.wr_data
                                                  : mem[req.payload.req.addr];
        end
    end

    // only requests may be routed into a scratchpad
    a_req_opcode: assert property (@(posedge clk) disable iff (reset)
        accept |-> req.opcode inside {OP_RD_REQ, OP_WR_REQ});

endmodule

// File: src/tile_router.sv
// five-port router, row-first routing, fixed priority with no starvation guard, no u-turns
`timescale 1ns/1ns

module tile_router (
    input  logic                    clk,
    input  logic                    reset,
    input  common_pkg::t_tile_id    local_tile_id,
    // local
    input  logic                    in_local_req_valid,
    input  common_pkg::t_tile_trans in_local_req,
    output common_pkg::t_fab_ready  out_local_ready,
    output logic                    out_local_req_valid,
    output common_pkg::t_tile_trans out_local_req,
    input  common_pkg::t_fab_ready  in_local_ready,
    // north
    input  logic                    in_north_req_valid,
    input  common_pkg::t_tile_trans in_north_req,
    output common_pkg::t_fab_ready  out_north_ready,
    output logic                    out_north_req_valid,
    output common_pkg::t_tile_trans out_north_req,
    input  common_pkg::t_fab_ready  in_north_ready,
    // east
    input  logic                    in_east_req_valid,
    input  common_pkg::t_tile_trans in_east_req,
    output common_pkg::t_fab_ready  out_east_ready,
    output logic                    out_east_req_valid,
    output common_pkg::t_tile_trans out_east_req,
    input  common_pkg::t_fab_ready  in_east_ready,
    // south
    input  logic                    in_south_req_valid,
    input  common_pkg::t_tile_trans in_south_req,
    output common_pkg::t_fab_ready  out_south_ready,
    output logic                    out_south_req_valid,
    output common_pkg::t_tile_trans out_south_req,
    input  common_pkg::t_fab_ready  in_south_ready,
    // west
    input  logic                    in_west_req_valid,
    input  common_pkg::t_tile_trans in_west_req,
    output common_pkg::t_fab_ready  out_west_ready,
    output logic                    out_west_req_valid,
    output common_pkg::t_tile_trans out_west_req,
    input  common_pkg::t_fab_ready  in_west_ready
);
    import common_pkg::*;
    import route_pkg::*;

    // outputs reachable from each input, indexed by input port
    // a westbound packet never turns into a column, an eastbound one only
    // where the host enters tile [1,1], so ready paths stay free of loops
    localparam t_port_vec TURNS [NUM_PORTS] = '{
        5'b11110, 5'b11101, 5'b10001, 5'b10111, 5'b01111
    };

    logic        [NUM_PORTS-1:0] in_vld;
    t_tile_trans [NUM_PORTS-1:0] in_trans;
    t_port_vec                   down_rdy;
    t_port_vec                   acc_rdy;
    t_dir        [NUM_PORTS-1:0] route;
    // req and grant are per output, one bit per input
    t_port_vec   [NUM_PORTS-1:0] req;
    t_port_vec   [NUM_PORTS-1:0] grant;
    // inputs whose valid and ready meet, per output
    t_port_vec   [NUM_PORTS-1:0] taken;
    t_port_vec                   free;
    logic        [NUM_PORTS-1:0] out_vld_q;
    t_tile_trans [NUM_PORTS-1:0] out_q;

    assign in_vld   = {in_west_req_valid, in_south_req_valid, in_east_req_valid,
                       in_north_req_valid, in_local_req_valid};
    assign in_trans = {in_west_req, in_south_req, in_east_req, in_north_req, in_local_req};
    assign down_rdy = {in_west_ready, in_south_ready, in_east_ready, in_north_ready,
                       in_local_ready};

    assign {out_west_ready, out_south_ready, out_east_ready, out_north_ready,
            out_local_ready} = acc_rdy;
    assign {out_west_req_valid, out_south_req_valid, out_east_req_valid,
            out_north_req_valid, out_local_req_valid} = out_vld_q;
    assign {out_west_req, out_south_req, out_east_req, out_north_req,
            out_local_req} = out_q;

    // rows first, larger row is south, larger column is east
    function automatic t_dir next_hop(t_tile_id dst, t_tile_id here);
        if (dst.row > here.row) return DIR_SOUTH;
        if (dst.row < here.row) return DIR_NORTH;
        if (dst.col > here.col) return DIR_EAST;
        if (dst.col < here.col) return DIR_WEST;
        return DIR_LOCAL;
    endfunction

    //============================================================
    // route and arbitrate
    //============================================================
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            route[i] = next_hop(in_trans[i].dst, local_tile_id);
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            // empty, or draining on this edge
            free[o] = !out_vld_q[o] || down_rdy[o];
            for (int i = 0; i < NUM_PORTS; i++) begin
                req[o][i] = in_vld[i] && (route[i] == t_dir'(o)) && TURNS[i][o];
            end
            // lowest set bit wins
            grant[o] = free[o] ? (req[o] & (~req[o] + 5'd1)) : '0;
        end
        // looks only at higher priority competitors, never at this input's own valid
        for (int i = 0; i < NUM_PORTS; i++) begin
            acc_rdy[i] = TURNS[i][route[i]] && free[route[i]] &&
                         !(|(req[route[i]] & t_port_vec'((5'd1 << i) - 5'd1)));
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                taken[o][i] = in_vld[i] && acc_rdy[i] && (route[i] == t_dir'(o));
            end
        end
    end

    //============================================================
    // output registers
    //============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            out_vld_q <= '0;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (free[o])
                    out_vld_q[o] <= |grant[o];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (grant[o][i])
                    out_q[o] <= in_trans[i];
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_chk
        a_one_grant: assert property (@(posedge clk) disable iff (reset)
            $onehot0(taken[o]) && taken[o] == grant[o]);
        // the neighbour's output register holds until this router takes it
        a_hold: assert property (@(posedge clk) disable iff (reset)
            in_vld[o] && !acc_rdy[o] |=> in_vld[o] && $stable(in_trans[o]));
    end

endmodule

// File: src/route_pkg.sv
// router port types; the enum order is also the arbitration priority, local first, west last
package route_pkg;

    typedef enum logic [2:0] {
        DIR_LOCAL,
        DIR_NORTH,
        DIR_EAST,
        DIR_SOUTH,
        DIR_WEST
    } t_dir;

    localparam int NUM_PORTS = 5;

    // one bit per port, indexed by t_dir
    typedef logic [NUM_PORTS-1:0] t_port_vec;

endpackage

// File: src/common_pkg.sv
// transaction formats; the opcode alone tells which payload view is valid, no parity or error code
`include "fabric_config.svh"

package common_pkg;

    // column and row inside the 5x5 frame, tiles sit at 1..3
    typedef struct packed {
        logic [3:0] col;
        logic [3:0] row;
    } t_tile_id;

    typedef enum logic [1:0] {
        OP_RD_REQ,
        OP_WR_REQ,
        OP_RD_RSP,
        OP_WR_ACK
    } t_opcode;

    localparam int ADDR_W = $clog2(`MEM_DEPTH);

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0] wr_data;
    } t_req_view;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [`DATA_W-1:0] rd_data;
    } t_rsp_view;

    // requests use .req, responses and acks use .rsp
    typedef union packed {
        t_req_view req;
        t_rsp_view rsp;
    } t_payload;

    typedef struct packed {
        t_opcode  opcode;
        t_tile_id dst;
        t_tile_id src;
        t_payload payload;
    } t_tile_trans;

    typedef logic t_fab_ready;

    // host hangs off the west side of tile [1,1]
    localparam t_tile_id HOST_ID = '{col: 4'd0, row: 4'd1};

endpackage

// File: src/fabric_config.svh
// mesh and scratchpad sizes are fixed at build time; tile ids hold coordinates up to 15 only
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// mesh size in tiles
`define FAB_COLS 3
`define FAB_ROWS 3

// scratchpad words per tile, power of two, at most 16 to fit the 4 bit address field
`define MEM_DEPTH 16

// data field of a transaction
`define DATA_W 24

`endif
